//--- common/ppu_settings.svh
/*
 * Raster geometry of the video timing controller.
 * Beam limits, window edges and the background fetch group size.
 */
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// ----------------------------------------
// Beam geometry
// ----------------------------------------
`define PPU_H_LAST      9'd339  // Last dot of a line
`define PPU_V_LAST      9'd261  // Last line, interlaced even field adds one
`define PPU_V_SHORT     9'd240  // Short line when progressive and field 1
`define PPU_LONG_DOTS   9'd4    // 5-clock dots at line start

// ----------------------------------------
// Display windows
// ----------------------------------------
`define PPU_VIS_FIRST   9'd1    // First visible line
`define PPU_VIS_END     9'd225  // Visible end, no overscan
`define PPU_VIS_END_OS  9'd240  // Visible end with overscan
`define PPU_FETCH_START 9'd5    // Fetch window opens here
`define PPU_FETCH_STOP  9'd269  // Fetch window closes here
`define PPU_PIPE_DELAY  9'd16   // Fetch to colour output in dots
`define PPU_H_OFFSET    9'd6    // Dot where x_fetch is 0

// ----------------------------------------
// Fetch scheduler
// ----------------------------------------
`define PPU_FETCH_SLOTS 9'd8    // Slots per fetch group

`endif

//--- common/ppu_pkg.sv
/*
 * Shared types of the video timing controller.
 * Beam counters, coordinates, layer modes and the bundled buses.
 */
`default_nettype none

package ppu_pkg;

    typedef logic [2:0] dot_t;          // Clock within a dot
    typedef logic [8:0] hcount_t;       // Dot in line
    typedef logic [8:0] vcount_t;       // Line in frame
    typedef logic [8:0] xpos_t;         // Fetch x
    typedef logic [8:0] coord_t;        // Output pixel coordinate
    typedef logic [2:0] screen_mode_t;  // Screen modes 0..7
    typedef logic [1:0] layer_t;        // Background layer index
    typedef logic [2:0] data_num_t;     // Data word offset

    // Per-layer fetch format
    typedef enum logic [2:0] {
        LM_OPT2    = 3'd0,  // Offset-per-tile, two words or unused layer
        LM_2BPP    = 3'd1,
        LM_4BPP    = 3'd2,
        LM_8BPP    = 3'd3,
        LM_OPT1    = 3'd4,  // Offset-per-tile, one word
        LM_2BPP_HR = 3'd5,  // True high-res
        LM_4BPP_HR = 3'd6   // True high-res
    } layer_mode_t;

    typedef layer_mode_t [3:0] layer_modes_t;  // One per layer

    typedef struct packed {
        logic         overscan;
        logic         interlace;
        screen_mode_t mode;
    } screen_cfg_t;

    typedef struct packed {
        dot_t    dot;
        logic    dot_en;     // Last clock of the dot
        hcount_t h;
        vcount_t v;
        logic    field;
        logic    line_end;   // dot_en on the last dot
        logic    frame_end;  // line_end on the last line
    } beam_t;

    typedef struct packed {
        logic      map;     // Tile map or OPT read
        logic      data;    // Tile data read
        layer_t    target;
        data_num_t num;
    } fetch_t;

endpackage

`default_nettype wire

//--- hw/ppu_timing/dot_timer.sv
/*
 * Dot and beam counters.
 * Divides the clock into 4- and 5-clock dots and steps h, v and field.
 */
`default_nettype none

`include "ppu_settings.svh"

module dot_timer (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire ppu_pkg::screen_cfg_t cfg,
    output ppu_pkg::beam_t            beam
);

    ppu_pkg::dot_t    dot;
    ppu_pkg::hcount_t h;
    ppu_pkg::vcount_t v;
    logic             field;
    ppu_pkg::dot_t    dot_max;    // Last clock index of current dot
    ppu_pkg::vcount_t v_last;     // Last line of this field
    logic             dot_en;
    logic             line_end;
    logic             frame_end;

    // ----------------------------------------
    // Dot divider
    // ----------------------------------------
    // First four dots are long, except on the short line
    assign dot_max = ((h < `PPU_LONG_DOTS)
                      && (cfg.interlace || !field || v != `PPU_V_SHORT)) ? 3'd4 : 3'd3;
    assign dot_en = (dot == dot_max);

    always_ff @(posedge clk) begin
        if (reset) begin
            dot <= 3'd0;
        end else begin
            dot <= dot_en ? 3'd0 : dot + 3'd1;  // Restart every dot
        end
    end

    // ----------------------------------------
    // Beam counters
    // ----------------------------------------
    assign v_last    = (cfg.interlace && !field) ? `PPU_V_LAST + 9'd1 : `PPU_V_LAST;
    assign line_end  = dot_en && (h == `PPU_H_LAST);
    assign frame_end = line_end && (v == v_last);

    always_ff @(posedge clk) begin
        if (reset) begin
            h <= 9'd0;
        end else if (dot_en) begin
            h <= (h == `PPU_H_LAST) ? 9'd0 : h + 9'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            v <= 9'd0;
        end else if (line_end) begin
            v <= frame_end ? 9'd0 : v + 9'd1;  // Even interlaced field runs one line more
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            field <= 1'b0;
        end else if (dot_en && v == 9'd0 && h == 9'd1) begin
            field <= !field;  // Early in line 0
        end
    end

    assign beam = '{dot: dot, dot_en: dot_en, h: h, v: v, field: field,
                    line_end: line_end, frame_end: frame_end};

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_dot_range: assert property (@(posedge clk) disable iff (reset) dot <= 3'd4)
        else $error("dot counter ran past a long dot");
    a_h_range: assert property (@(posedge clk) disable iff (reset) h <= `PPU_H_LAST)
        else $error("h counter ran past the last dot");
    a_v_range: assert property (@(posedge clk) disable iff (reset) v <= `PPU_V_LAST + 9'd1)
        else $error("v counter ran past the last line");

endmodule

`default_nettype wire

//--- hw/ppu_timing/period_gen.sv
/*
 * Display window generator.
 * Vertical and horizontal windows, colour and line-buffer write strobes, pixel coordinates.
 */
`default_nettype none

`include "ppu_settings.svh"

module period_gen (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire ppu_pkg::screen_cfg_t cfg,
    input  wire ppu_pkg::beam_t       beam,
    output logic                      fetch_period,
    output logic                      color_period,
    output logic                      color_write,
    output logic                      dr_write_req,
    output ppu_pkg::coord_t           xout,
    output ppu_pkg::coord_t           yout
);

    // Colour stage lags fetch by the pipe, minus the prefetched group
    localparam ppu_pkg::hcount_t color_start = `PPU_FETCH_START + `PPU_PIPE_DELAY;
    localparam ppu_pkg::hcount_t color_stop  =
        `PPU_FETCH_STOP + `PPU_PIPE_DELAY - `PPU_FETCH_SLOTS;
    localparam ppu_pkg::hcount_t write_start = color_start + 9'd1;  // One dot after colour
    localparam ppu_pkg::hcount_t write_stop  = color_stop + 9'd1;

    ppu_pkg::vcount_t vis_end;
    logic             vis_v;     // Vertical visible window
    logic             fetch_h;
    logic             color_h;
    logic             write_h;
    logic             dr_line;   // Line buffer write enabled for this line
    logic [7:0]       x_rel;
    logic [7:0]       y_rel;

    function automatic logic win_next(input logic cur, input logic open, input logic close);
        if (open) begin
            return 1'b1;
        end
        if (close) begin
            return 1'b0;
        end
        return cur;
    endfunction

    assign vis_end = cfg.overscan ? `PPU_VIS_END_OS : `PPU_VIS_END;

    // ----------------------------------------
    // Window registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            vis_v <= 1'b0;
        end else begin
            vis_v <= win_next(vis_v, beam.v == `PPU_VIS_FIRST, beam.v == vis_end);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_h <= 1'b0;
            color_h <= 1'b0;
            write_h <= 1'b0;
        end else if (beam.dot_en) begin
            fetch_h <= win_next(fetch_h, beam.h == `PPU_FETCH_START, beam.h == `PPU_FETCH_STOP);
            color_h <= win_next(color_h, beam.h == color_start, beam.h == color_stop);
            write_h <= win_next(write_h, beam.h == write_start, beam.h == write_stop);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dr_line <= 1'b0;
        end else if (beam.line_end) begin
            // Lines 2 through visible end
            dr_line <= win_next(dr_line, beam.v == `PPU_VIS_FIRST, beam.v == vis_end);
        end
    end

    // ----------------------------------------
    // Strobes and coordinates
    // ----------------------------------------
    assign fetch_period = vis_v && fetch_h;
    assign color_period = vis_v && color_h;
    assign color_write  = vis_v && write_h && beam.dot[0];  // Two writes per dot
    assign dr_write_req = dr_line && (beam.h == 9'd0);      // Whole of dot 0

    assign x_rel = 8'(beam.h - (`PPU_H_OFFSET + `PPU_PIPE_DELAY + 9'd1));
    assign y_rel = 8'(beam.v - (`PPU_VIS_FIRST + 9'd1));
    assign xout  = {x_rel, beam.dot[1]};                    // Half-dot resolution
    assign yout  = {y_rel, cfg.interlace && beam.field};    // Odd field lines

    // Write trails the colour stage by one 4-clock dot
    a_write_after_color: assert property (@(posedge clk) disable iff (reset)
        color_write |-> $past(color_period, 4))
        else $error("color_write without colour stage one dot earlier");

endmodule

`default_nettype wire

//--- hw/bg_fetch/bg_fetch_sched.sv
/*
 * Background fetch scheduler.
 * Decodes layer formats per screen mode and the VRAM action of each fetch slot.
 */
`default_nettype none

`include "ppu_settings.svh"

module bg_fetch_sched (
    input  wire ppu_pkg::screen_cfg_t cfg,
    input  wire ppu_pkg::beam_t       beam,
    input  wire logic                 fetch_period,
    output ppu_pkg::fetch_t           fetch,
    output ppu_pkg::layer_modes_t     layer_modes,
    output ppu_pkg::xpos_t            x_fetch
);

    logic [2:0]      slot;  // Position in fetch group
    ppu_pkg::fetch_t raw;   // Ungated slot action

    // Map or data read of one layer
    function automatic ppu_pkg::fetch_t slot_op(input logic is_map,
                                                input ppu_pkg::layer_t layer,
                                                input ppu_pkg::data_num_t num);
        ppu_pkg::fetch_t op;
        op.map    = is_map;
        op.data   = !is_map;
        op.target = layer;
        op.num    = num;
        return op;
    endfunction

    assign x_fetch = beam.h - `PPU_H_OFFSET;
    assign slot    = 3'(x_fetch % `PPU_FETCH_SLOTS);

    // ----------------------------------------
    // Layer formats
    // ----------------------------------------
    always_comb begin
        layer_modes = {4{ppu_pkg::LM_OPT2}};  // Unused layers
        unique case (cfg.mode)
            3'd0: layer_modes = {4{ppu_pkg::LM_2BPP}};
            3'd1: begin
                layer_modes[0] = ppu_pkg::LM_4BPP;
                layer_modes[1] = ppu_pkg::LM_4BPP;
                layer_modes[2] = ppu_pkg::LM_2BPP;
            end
            3'd2: begin
                layer_modes[0] = ppu_pkg::LM_4BPP;
                layer_modes[1] = ppu_pkg::LM_4BPP;  // Layer 2 is OPT
            end
            3'd3: begin
                layer_modes[0] = ppu_pkg::LM_8BPP;
                layer_modes[1] = ppu_pkg::LM_4BPP;
            end
            3'd4: begin
                layer_modes[0] = ppu_pkg::LM_8BPP;
                layer_modes[1] = ppu_pkg::LM_2BPP;
                layer_modes[2] = ppu_pkg::LM_OPT1;
            end
            3'd5: begin
                layer_modes[0] = ppu_pkg::LM_4BPP_HR;
                layer_modes[1] = ppu_pkg::LM_2BPP_HR;
            end
            3'd6: layer_modes[0] = ppu_pkg::LM_4BPP_HR;
            3'd7: ;  // Mode 7 has its own fetch path
        endcase
    end

    // ----------------------------------------
    // Slot schedule
    // ----------------------------------------
    always_comb begin
        raw = '0;
        unique case (cfg.mode)
            3'd0: raw = slot_op(!slot[0], slot[2:1], 3'd0);  // Map and data per layer
            3'd1, 3'd2: begin
                unique case (slot)
                    3'd0: raw = slot_op(1'b1, 2'd0, 3'd0);
                    3'd1: raw = slot_op(1'b0, 2'd0, 3'd0);
                    3'd2: raw = slot_op(1'b0, 2'd0, 3'd2);
                    3'd3: raw = slot_op(1'b1, 2'd1, 3'd0);
                    3'd4: raw = slot_op(1'b0, 2'd1, 3'd0);
                    3'd5: raw = slot_op(1'b0, 2'd1, 3'd2);
                    3'd6: raw = slot_op(1'b1, 2'd2, 3'd0);
                    3'd7: raw = slot_op(1'b0, 2'd2, 3'd0);
                endcase
                if (cfg.mode == 3'd2 && slot[2:1] == 2'b11) begin
                    raw = slot_op(1'b1, 2'd2, {2'b00, slot[0]});  // OPT horizontal and vertical
                end
            end
            3'd3, 3'd4: begin
                unique case (slot)
                    3'd0: raw = slot_op(1'b1, 2'd0, 3'd0);
                    3'd1: raw = slot_op(1'b0, 2'd0, 3'd0);
                    3'd2: raw = slot_op(1'b0, 2'd0, 3'd2);
                    3'd3: raw = slot_op(1'b0, 2'd0, 3'd4);
                    3'd4: raw = slot_op(1'b0, 2'd0, 3'd6);
                    3'd5: raw = slot_op(1'b1, 2'd1, 3'd0);
                    3'd6: raw = slot_op(1'b0, 2'd1, 3'd0);
                    3'd7: raw = slot_op(1'b0, 2'd1, 3'd2);
                endcase
                if (cfg.mode == 3'd4 && slot == 3'd7) begin
                    raw = slot_op(1'b1, 2'd2, 3'd0);  // Single OPT word
                end
            end
            3'd5, 3'd6: begin
                unique case (slot)
                    3'd0: raw = slot_op(1'b1, 2'd0, 3'd0);
                    3'd1: raw = slot_op(1'b0, 2'd0, 3'd0);
                    3'd2: raw = slot_op(1'b0, 2'd0, 3'd1);  // High-res halves
                    3'd3: raw = slot_op(1'b0, 2'd0, 3'd2);
                    3'd4: raw = slot_op(1'b0, 2'd0, 3'd3);
                    3'd5: raw = slot_op(1'b1, 2'd1, 3'd0);
                    3'd6: raw = slot_op(1'b0, 2'd1, 3'd0);
                    3'd7: raw = slot_op(1'b0, 2'd1, 3'd1);
                endcase
                if (cfg.mode == 3'd6 && slot == 3'd5) begin
                    raw = '0;  // Idle slot
                end else if (cfg.mode == 3'd6 && slot[2:1] == 2'b11) begin
                    raw = slot_op(1'b1, 2'd2, {2'b00, slot[0]});
                end
            end
            3'd7: raw = slot_op(slot == 3'd0, 2'd0, 3'd0);  // One map then data
        endcase
    end

    assign fetch = '{map: fetch_period && raw.map, data: fetch_period && raw.data,
                     target: raw.target, num: raw.num};

    always_comb begin
        a_map_data_excl: assert (!(fetch.map && fetch.data))
            else $error("map and data fetch in the same slot");
    end

endmodule

`default_nettype wire

//--- hw/ppu_controller.sv
/*
 * Raster timing controller top.
 * Beam counters, display windows and background fetch schedule.
 */
`default_nettype none

module ppu_controller (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire ppu_pkg::screen_cfg_t cfg,
    output ppu_pkg::beam_t            beam,
    output ppu_pkg::xpos_t            x_fetch,
    output ppu_pkg::coord_t           xout,
    output ppu_pkg::coord_t           yout,
    output logic                      color_period,
    output logic                      color_write,
    output logic                      dr_write_req,
    output ppu_pkg::fetch_t           fetch,
    output ppu_pkg::layer_modes_t     layer_modes
);

    logic fetch_period;  // Fetch window inside visible lines

    dot_timer u_dot_timer (
        .clk   (clk),
        .reset (reset),
        .cfg   (cfg),
        .beam  (beam)
    );

    period_gen u_period_gen (
        .clk          (clk),
        .reset        (reset),
        .cfg          (cfg),
        .beam         (beam),
        .fetch_period (fetch_period),
        .color_period (color_period),
        .color_write  (color_write),
        .dr_write_req (dr_write_req),
        .xout         (xout),
        .yout         (yout)
    );

    bg_fetch_sched u_bg_fetch_sched (
        .cfg          (cfg),
        .beam         (beam),
        .fetch_period (fetch_period),
        .fetch        (fetch),
        .layer_modes  (layer_modes),
        .x_fetch      (x_fetch)
    );

endmodule

`default_nettype wire

//--- sim/tb_checks.svh
/*
 * Testbench compare tasks and reference tables.
 * Typed checks with error counting, layer format and fetch slot references.
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int errors = 0;  // Failed compares
int checks = 0;  // All compares

// ----------------------------------------
// Typed compares
// ----------------------------------------
task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERR t=%0t %s expected %b got %b", $time, name, exp, act);
    end
endtask

task automatic check_h(input string name, input ppu_pkg::hcount_t exp,
                       input ppu_pkg::hcount_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

task automatic check_v(input string name, input ppu_pkg::vcount_t exp,
                       input ppu_pkg::vcount_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

task automatic check_xpos(input string name, input ppu_pkg::xpos_t exp,
                          input ppu_pkg::xpos_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

task automatic check_coord(input string name, input ppu_pkg::coord_t exp,
                           input ppu_pkg::coord_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
        errors++;
        $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, act);
    end
endtask

task automatic check_modes(input string name, input ppu_pkg::layer_modes_t exp,
                           input ppu_pkg::layer_modes_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
    end
endtask

// Target and word only compared where the schedule names them
task automatic check_fetch(input string name, input ppu_pkg::fetch_t exp,
                           input ppu_pkg::fetch_t act, input bit tgt_def, input bit num_def);
    logic bad;
    bad = (act.map !== exp.map) || (act.data !== exp.data);
    bad = bad || (tgt_def && act.target !== exp.target);
    bad = bad || (num_def && act.num !== exp.num);
    checks++;
    if (bad) begin
        errors++;
        $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
    end
endtask

// ----------------------------------------
// Reference tables
// ----------------------------------------
// Layer 0 first, one digit per layer
string modes_tbl [8] = '{"1111", "2210", "2200", "3200", "3140", "6500", "6000", "0000"};

// Three chars per slot: kind, layer, word; - is unnamed
string sched_tbl [8] = '{
    "M0-D00M1-D10M2-D20M3-D30",
    "M0-D00D02M1-D10D12M2-D20",
    "M0-D00D02M1-D10D12M20M21",
    "M0-D00D02D04D06M1-D10D12",
    "M0-D00D02D04D06M1-D10M20",
    "M0-D00D01D02D03M1-D10D11",
    "M0-D00D01D02D03---M20M21",
    "M--D--D--D--D--D--D--D--"
};

function automatic ppu_pkg::layer_modes_t ref_modes(input ppu_pkg::screen_mode_t m);
    ppu_pkg::layer_modes_t r;
    for (int l = 0; l < 4; l++) begin
        r[l] = ppu_pkg::layer_mode_t'(modes_tbl[m].getc(l) - "0");
    end
    return r;
endfunction

task automatic ref_fetch(input ppu_pkg::screen_mode_t m, input int slot,
                         output ppu_pkg::fetch_t e, output bit tgt_def, output bit num_def);
    byte kind;
    byte tgt;
    byte num;
    kind    = sched_tbl[m].getc(3 * slot);
    tgt     = sched_tbl[m].getc(3 * slot + 1);
    num     = sched_tbl[m].getc(3 * slot + 2);
    e       = '0;
    e.map   = (kind == "M");
    e.data  = (kind == "D");
    tgt_def = (tgt != "-");
    num_def = (num != "-");
    if (tgt_def) e.target = ppu_pkg::layer_t'(tgt - "0");
    if (num_def) e.num = ppu_pkg::data_num_t'(num - "0");
endtask

`endif

//--- sim/tb_ppu_controller.sv
/*
 * Testbench for the raster timing controller.
 * Directed tests of reset, beam lengths, layer formats, fetch slots and strobes.
 */
`default_nettype none

module tb_ppu_controller;

    localparam longint watchdog_limit = 64'd5 * 263 * 1364 * 100;  // Five longest frames

    logic                  clk;
    logic                  reset;
    ppu_pkg::screen_cfg_t  cfg;
    ppu_pkg::beam_t        beam;
    ppu_pkg::xpos_t        x_fetch;
    ppu_pkg::coord_t       xout;
    ppu_pkg::coord_t       yout;
    logic                  color_period;
    logic                  color_write;
    logic                  dr_write_req;
    ppu_pkg::fetch_t       fetch;
    ppu_pkg::layer_modes_t layer_modes;

    `include "tb_checks.svh"

    ppu_controller dut (
        .clk          (clk),
        .reset        (reset),
        .cfg          (cfg),
        .beam         (beam),
        .x_fetch      (x_fetch),
        .xout         (xout),
        .yout         (yout),
        .color_period (color_period),
        .color_write  (color_write),
        .dr_write_req (dr_write_req),
        .fetch        (fetch),
        .layer_modes  (layer_modes)
    );

    initial clk = 1'b0;
    always #50 clk = !clk;

    // ----------------------------------------
    // Test tasks
    // ----------------------------------------
    task automatic check_idle(input string when);
        check_h({when, " h"}, 9'd0, beam.h);
        check_v({when, " v"}, 9'd0, beam.v);
        check_bit({when, " field"}, 1'b0, beam.field);
        check_bit({when, " dot"}, 1'b0, beam.dot != 3'd0);
        check_bit({when, " color_write"}, 1'b0, color_write);
        check_bit({when, " dr_write_req"}, 1'b0, dr_write_req);
        check_bit({when, " fetch.map"}, 1'b0, fetch.map);
        check_bit({when, " fetch.data"}, 1'b0, fetch.data);
    endtask

    task automatic reset_state();
        repeat (7) begin
            @(negedge clk);
            check_idle("in reset");
        end
        @(posedge clk);                 // Eighth edge under reset
        #10 reset = 1'b0;
        #10 check_idle("after reset");  // Still clock 0 of line 0
    endtask

    // Walks one frame from the next clock, checking every line length
    task automatic count_frame(output int lines, output logic field);
        int clocks;
        int dots;
        int exp;
        clocks = 0;
        dots   = 0;
        lines  = 0;
        forever begin
            @(negedge clk);
            clocks++;
            dots += beam.dot_en;
            if (beam.line_end) begin
                exp = (!cfg.interlace && beam.field && beam.v == 9'd240) ? 1360 : 1364;
                check_count("clocks per line", exp, clocks);
                check_count("dots per line", 340, dots);
                if (lines == 0) field = beam.field;  // Toggle already done at h 1
                lines++;
                clocks = 0;
                dots   = 0;
                if (beam.frame_end) break;
            end
        end
    endtask

    task automatic line_frame_length();
        int   lines;
        logic f_a;
        logic f_b;
        count_frame(lines, f_a);  // Progressive, field 1 has the short line
        check_v("lines per frame", 9'd262, ppu_pkg::vcount_t'(lines));
        check_bit("first field", 1'b1, f_a);
        @(posedge clk);
        #10 cfg.interlace = 1'b1;
        count_frame(lines, f_b);  // Even interlaced field
        check_v("lines per even field", 9'd263, ppu_pkg::vcount_t'(lines));
        check_bit("field toggle", !f_a, f_b);
    endtask

    task automatic color_window(input logic os);
        ppu_pkg::vcount_t vis_end;
        int               per_line;
        int               dr_lines;
        int               pix;    // Pixels due so far in this line
        int               lines;  // Lines since frame start
        logic             exp_cw;
        logic             exp_cp;
        logic             exp_dr;
        vis_end  = os ? 9'd240 : 9'd225;
        per_line = 0;
        dr_lines = 0;
        pix      = 0;
        lines    = 0;
        @(posedge clk);
        #10 begin
            cfg.overscan  = os;
            cfg.interlace = 1'b0;
        end
        forever begin
            @(negedge clk);
            exp_cw = beam.v >= 9'd1 && beam.v < vis_end && beam.h >= 9'd23
                     && beam.h <= 9'd278 && beam.dot[0];
            exp_cp = beam.v >= 9'd1 && beam.v < vis_end && beam.h >= 9'd22
                     && beam.h <= 9'd277;
            exp_dr = beam.v >= 9'd2 && beam.v <= vis_end && beam.h == 9'd0;
            check_bit("color_write", exp_cw, color_write);
            check_bit("color_period", exp_cp, color_period);
            check_bit("dr_write_req", exp_dr, dr_write_req);
            if (exp_cw) begin
                check_coord("xout", ppu_pkg::coord_t'(pix), xout);  // Two pixels per dot
                check_coord("yout", ppu_pkg::coord_t'(2 * (lines - 2)), yout);
                pix++;
            end
            per_line += color_write;
            if (beam.h == 9'd0 && beam.dot == 3'd0 && dr_write_req) dr_lines++;
            if (beam.line_end) begin
                if (beam.v >= 9'd1 && beam.v < vis_end) begin
                    check_count("color_write per line", 512, per_line);
                end
                per_line = 0;
                pix      = 0;
                lines++;
                if (beam.frame_end) break;
            end
        end
        check_count("dr_write_req lines", vis_end - 1, dr_lines);
    endtask

    task automatic fetch_schedule();
        ppu_pkg::screen_mode_t order [8];
        ppu_pkg::screen_mode_t tmp;
        ppu_pkg::fetch_t       exp;
        bit                    tgt_def;
        bit                    num_def;
        int                    j;
        int                    k;
        int                    dot_idx;  // Dot in line from the clock count
        for (int i = 0; i < 8; i++) order[i] = ppu_pkg::screen_mode_t'(i);
        for (int i = 7; i > 0; i--) begin  // Shuffle
            j        = $urandom % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        @(posedge clk);
        #10 cfg.mode = order[0];
        do @(negedge clk); while (beam.v != 9'd10);
        k = 0;
        while (beam.v == 9'd10) begin
            dot_idx = (k < 20) ? k / 5 : 4 + (k - 20) / 4;  // Four long dots open the line
            exp     = '0;
            tgt_def = 1'b0;
            num_def = 1'b0;
            if (dot_idx >= 6 && dot_idx <= 269) begin
                ref_fetch(cfg.mode, (dot_idx - 6) % 8, exp, tgt_def, num_def);
            end
            check_h("h", ppu_pkg::hcount_t'(dot_idx), beam.h);
            check_fetch("fetch", exp, fetch, tgt_def, num_def);
            check_xpos("x_fetch", ppu_pkg::xpos_t'(dot_idx - 6), x_fetch);
            @(posedge clk);
            k++;
            #10 if (k % 40 == 0) cfg.mode = order[(k / 40) % 8];  // Next mode in sweep
            @(negedge clk);
        end
    endtask

    task automatic layer_mode_table();
        for (int m = 0; m < 8; m++) begin
            @(posedge clk);
            #10 cfg.mode = ppu_pkg::screen_mode_t'(m);
            @(negedge clk);
            check_modes("layer_modes", ref_modes(cfg.mode), layer_modes);
        end
    endtask

    // ----------------------------------------
    // Sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'hbe3e));
        reset = 1'b1;
        cfg   = '0;
        reset_state();
        line_frame_length();
        color_window(1'b0);
        color_window(1'b1);
        fetch_schedule();
        layer_mode_table();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_limit);
        $display("Watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
+incdir+sim
common/ppu_pkg.sv
hw/ppu_timing/dot_timer.sv
hw/ppu_timing/period_gen.sv
hw/bg_fetch/bg_fetch_sched.sv
hw/ppu_controller.sv
sim/tb_ppu_controller.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ppu_controller
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
FILELIST  ?= project.f

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard common/*.sv common/*.svh hw/*.sv hw/*/*.sv sim/*.sv sim/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
